/* rtl/spiCmdPkg.sv */
`default_nettype none

// serial side definitions: opcodes, sequencer states, byte transport

package spiCmdPkg;

   // one byte as it travels on the serial line
   typedef logic [7:0] spiByteT;

   // instruction set kept from the full part
   typedef enum logic [7:0]
   {
      opWrsr  = 8'h01,
      opWrite = 8'h02,
      opRead  = 8'h03,
      opWrdi  = 8'h04,
      opRdsr  = 8'h05,
      opWren  = 8'h06,
      opRdid  = 8'h9F
   } opcodeT;

   typedef enum logic [3:0]
   {
      idle,
      getOpcode,
      getAddrHigh,
      getAddrLow,
      writeData,
      readData,
      statusOut,
      statusIn,
      idOut,
      ignore
   } cmdStateT;

   // received byte, valid for a single system clock
   typedef struct packed
   {
      spiByteT data;
      logic    valid;
   } spiRxT;

   // device ID: continuation bytes, then three code bytes msb first
   localparam int          ID_CONT_BYTES = 6;
   localparam logic [23:0] ID_CODE       = 24'h2C_1A_08;
   localparam int          ID_LEN        = ID_CONT_BYTES + 3;

   // system clock cycles per sck period, at least
   localparam int SCK_MIN_DIV = 16;

endpackage

`default_nettype wire

/* rtl/memMapPkg.sv */
`default_nettype none

// memory side definitions: array geometry, protection, status and requests

package memMapPkg;

   import spiCmdPkg::*;

   localparam int ADDR_BITS = 13;
   localparam int MEM_DEPTH = 1 << ADDR_BITS;

   typedef logic [ADDR_BITS-1:0] addrT;

   // protected regions always run up to the top address
   localparam addrT HALF_BASE    = addrT'(MEM_DEPTH / 2);
   localparam addrT QUARTER_BASE = addrT'(MEM_DEPTH - MEM_DEPTH / 4);

   // 00 none, 01 upper quarter, 10 upper half, 11 whole array
   typedef logic [1:0] bpT;

   // bit 7 and bits 6:4 read zero, bit 0 is the busy bit of an FRAM
   typedef struct packed
   {
      logic [3:0] rsvdHigh;
      bpT         bp;
      logic       wel;
      logic       rsvdLow;
   } statusRegT;

   typedef struct packed
   {
      logic    wrEn;
      logic    rdEn;
      addrT    addr;
      spiByteT data;
   } memReqT;

endpackage

`default_nettype wire

/* rtl/spiFrontEnd.sv */
`default_nettype none

module spiFrontEnd
   import spiCmdPkg::*;
(
   input  logic    CSB,
   input  logic    reset,
   input  logic    chipSelectN,
   input  logic    sck,
   input  logic    sdi,
   input  logic    txLoad,
   input  spiByteT txByte,
   output spiRxT   rxByte,
   output logic    deselect,
   output logic    sdo
);

   logic [1:0] csSync;
   logic [1:0] sckSync;
   logic [1:0] sdiSync;
   logic       sckPrev;
   logic       csPrev;
   logic       sckEdge;
   logic       sckRise;
   logic       sckFall;
   logic       selected;
   logic [2:0] bitCnt;
   logic       rxValid;
   spiByteT    rxShift;
   spiByteT    txShift;

   // -------------------------------------------------------------------
   // pin synchronizers and edge detect
   // -------------------------------------------------------------------

   always_ff @(posedge CSB)
   begin
      if (reset)
      begin
         csSync  <= 2'b11;
         sckSync <= 2'b00;
         csPrev  <= 1'b1;
         sckPrev <= 1'b0;
      end
      else
      begin
         csSync  <= {csSync[0], chipSelectN};
         sckSync <= {sckSync[0], sck};
         csPrev  <= csSync[1];
         sckPrev <= sckSync[1];
      end
   end

   // sdi goes through the same two stages so it lines up with sck
   always_ff @(posedge CSB)
   begin
      sdiSync <= {sdiSync[0], sdi};
   end

   assign selected = ~csSync[1];
   assign sckEdge  = sckSync[1] ^ sckPrev;
   assign sckRise  = sckEdge & sckSync[1];
   assign sckFall  = sckEdge & ~sckSync[1];

   // -------------------------------------------------------------------
   // receive path
   // -------------------------------------------------------------------

   always_ff @(posedge CSB)
   begin
      if (reset)
      begin
         bitCnt   <= '0;
         rxValid  <= 1'b0;
         deselect <= 1'b0;
      end
      else
      begin
         rxValid  <= 1'b0;
         deselect <= csSync[1] & ~csPrev;
         if (!selected)
            bitCnt <= '0;
         else if (sckRise)
         begin
            bitCnt <= bitCnt + 3'd1;
            // eighth bit completes the byte
            if (bitCnt == 3'd7)
               rxValid <= 1'b1;
         end
      end
   end

   // msb arrives first
   always_ff @(posedge CSB)
   begin
      if (selected && sckRise)
         rxShift <= {rxShift[6:0], sdiSync[1]};
   end

   // shifter stays put for a whole sck period after the last bit
   assign rxByte = '{data: rxShift, valid: rxValid};

   // -------------------------------------------------------------------
   // transmit path
   // -------------------------------------------------------------------

   always_ff @(posedge CSB)
   begin
      if (reset)
      begin
         txShift <= '0;
         sdo     <= 1'b0;
      end
      else if (!selected)
      begin
         txShift <= '0;
         sdo     <= 1'b0;
      end
      else if (txLoad)
         txShift <= txByte;
      else if (sckFall)
      begin
         sdo     <= txShift[7];
         // zeros fill in behind, so an unloaded byte reads as 00
         txShift <= {txShift[6:0], 1'b0};
      end
   end

   // half period of sck must cover the load latency of the sequencer
   sckEdgeSpacing: assert property (@(posedge CSB) disable iff (reset)
      sckEdge |=> !sckEdge [*(SCK_MIN_DIV / 2 - 1)])
      else $error("sck edges closer than %0d system clocks", SCK_MIN_DIV / 2);

endmodule

`default_nettype wire

/* rtl/cmdSequencer.sv */
`default_nettype none

module cmdSequencer
   import spiCmdPkg::*;
   import memMapPkg::*;
(
   input  logic      CSB,
   input  logic      reset,
   input  spiRxT     rxByte,
   input  logic      deselect,
   input  spiByteT   rdData,
   output logic      txLoad,
   output spiByteT   txByte,
   output memReqT    memReq,
   output statusRegT status
);

   cmdStateT   state;
   opcodeT     curOp;
   opcodeT     rxOp;
   addrT       addr;
   addrT       reqAddr;
   addrT       nextAddr;
   logic [3:0] idCnt;
   logic       rdPending;
   logic       rdStrobe;
   logic       wrStrobe;
   logic       loadReq;
   spiByteT    loadByte;

   // byte idx of the device ID stream
   function automatic spiByteT idByte(input logic [3:0] idx);
      spiByteT value;
      if (idx < ID_CONT_BYTES)
         value = 8'h7F;
      else
         value = ID_CODE[8 * (ID_LEN - 1 - idx) +: 8];
      return value;
   endfunction

   // -------------------------------------------------------------------
   // memory requests
   // -------------------------------------------------------------------

   assign rxOp = opcodeT'(rxByte.data);

   // during the low address byte the full address is not yet registered
   assign reqAddr  = (state == getAddrLow) ? {addr[ADDR_BITS-1:8], rxByte.data} : addr;
   assign nextAddr = (reqAddr == addrT'(MEM_DEPTH - 1)) ? '0 : reqAddr + 1'b1;

   assign rdStrobe = rxByte.valid
                     && ((state == getAddrLow && curOp == opRead) || state == readData);
   assign wrStrobe = rxByte.valid && state == writeData;

   assign memReq = '{wrEn: wrStrobe, rdEn: rdStrobe, addr: reqAddr, data: rxByte.data};

   // -------------------------------------------------------------------
   // transmit byte selection
   // -------------------------------------------------------------------

   always_comb
   begin
      loadReq  = 1'b0;
      loadByte = rdData;
      // array data comes back one cycle after the read strobe
      if (rdPending)
         loadReq = 1'b1;
      else if (rxByte.valid)
      begin
         if ((state == getOpcode && rxOp == opRdsr) || state == statusOut)
         begin
            loadReq  = 1'b1;
            loadByte = status;
         end
         else if (state == getOpcode && rxOp == opRdid)
         begin
            loadReq  = 1'b1;
            loadByte = idByte(4'd0);
         end
         else if (state == idOut)
         begin
            loadReq  = 1'b1;
            loadByte = idByte(idCnt);
         end
      end
   end

   always_ff @(posedge CSB)
   begin
      if (loadReq)
         txByte <= loadByte;
   end

   // -------------------------------------------------------------------
   // command FSM
   // -------------------------------------------------------------------

   always_ff @(posedge CSB)
   begin
      if (reset)
      begin
         state     <= getOpcode;
         curOp     <= opWrdi;
         addr      <= '0;
         idCnt     <= '0;
         status    <= '0;
         txLoad    <= 1'b0;
         rdPending <= 1'b0;
      end
      else
      begin
         txLoad    <= loadReq;
         rdPending <= rdStrobe;
         if (deselect)
         begin
            state <= getOpcode;
            // a finished write command drops the latch
            if (curOp == opWrsr || curOp == opWrite)
               status.wel <= 1'b0;
         end
         else if (rxByte.valid)
         begin
            case (state)
               getOpcode:
               begin
                  curOp <= rxOp;
                  case (rxOp)
                     opWren:
                     begin
                        status.wel <= 1'b1;
                        state      <= idle;
                     end
                     opWrdi:
                     begin
                        status.wel <= 1'b0;
                        state      <= idle;
                     end
                     opRdsr:
                        state <= statusOut;
                     opRead:
                        state <= getAddrHigh;
                     opRdid:
                     begin
                        idCnt <= 4'd1;
                        state <= idOut;
                     end
                     // write commands need the latch up front
                     opWrsr:
                        if (status.wel)
                           state <= statusIn;
                        else
                           state <= ignore;
                     opWrite:
                        if (status.wel)
                           state <= getAddrHigh;
                        else
                           state <= ignore;
                     default:
                        state <= ignore;
                  endcase
               end
               getAddrHigh:
               begin
                  addr[ADDR_BITS-1:8] <= rxByte.data[ADDR_BITS-9:0];
                  state               <= getAddrLow;
               end
               getAddrLow:
               begin
                  // a read is already under way for this address
                  if (curOp == opRead)
                  begin
                     addr  <= nextAddr;
                     state <= readData;
                  end
                  else
                  begin
                     addr  <= reqAddr;
                     state <= writeData;
                  end
               end
               readData, writeData:
                  addr <= nextAddr;
               statusIn:
               begin
                  status.bp <= rxByte.data[3:2];
                  state     <= idle;
               end
               idOut:
                  if (idCnt < ID_LEN - 1)
                     idCnt <= idCnt + 4'd1;
               default:
               begin
                  // idle, ignore and statusOut hold until deselect
               end
            endcase
         end
      end
   end

   // the latch was checked at the opcode and cannot drop before deselect
   writeNeedsWel: assert property (@(posedge CSB) disable iff (reset)
      memReq.wrEn |-> status.wel)
      else $error("memory write with write-enable latch clear");

endmodule

`default_nettype wire

/* rtl/framArray.sv */
`default_nettype none

module framArray
   import spiCmdPkg::*;
   import memMapPkg::*;
(
   input  logic      CSB,
   input  memReqT    memReq,
   input  statusRegT status,
   output spiByteT   rdData
);

   spiByteT mem [MEM_DEPTH];
   addrT    protBase;
   logic    protOn;
   logic    blocked;

   // array starts out holding all ones
   initial
   begin
      for (int i = 0; i < MEM_DEPTH; i++)
         mem[i] = 8'hFF;
   end

   // lower bound of the protected region, upper bound is the top address
   always_comb
   begin
      protOn   = 1'b1;
      protBase = '0;
      case (status.bp)
         2'b01:
            protBase = QUARTER_BASE;
         2'b10:
            protBase = HALF_BASE;
         2'b11:
            protBase = '0;
         default:
            protOn = 1'b0;
      endcase
   end

   assign blocked = protOn && (memReq.addr >= protBase);

   always_ff @(posedge CSB)
   begin
      if (memReq.wrEn && !blocked)
         mem[memReq.addr] <= memReq.data;
      if (memReq.rdEn)
         rdData <= mem[memReq.addr];
   end

endmodule

`default_nettype wire

/* rtl/framSpiTop.sv */
`default_nettype none

module framSpiTop
   import spiCmdPkg::*;
   import memMapPkg::*;
(
   input  logic CSB,
   input  logic reset,
   input  logic chipSelectN,
   input  logic sck,
   input  logic sdi,
   output logic sdo
);

   spiRxT     rxByte;
   logic      deselect;
   logic      txLoad;
   spiByteT   txByte;
   memReqT    memReq;
   statusRegT status;
   spiByteT   rdData;

   // serial pins to bytes and back
   spiFrontEnd frontEnd
   (
      .CSB         (CSB),
      .reset       (reset),
      .chipSelectN (chipSelectN),
      .sck         (sck),
      .sdi         (sdi),
      .txLoad      (txLoad),
      .txByte      (txByte),
      .rxByte      (rxByte),
      .deselect    (deselect),
      .sdo         (sdo)
   );

   cmdSequencer sequencer
   (
      .CSB      (CSB),
      .reset    (reset),
      .rxByte   (rxByte),
      .deselect (deselect),
      .rdData   (rdData),
      .txLoad   (txLoad),
      .txByte   (txByte),
      .memReq   (memReq),
      .status   (status)
   );

   framArray array
   (
      .CSB    (CSB),
      .memReq (memReq),
      .status (status),
      .rdData (rdData)
   );

endmodule

`default_nettype wire

/* bench/framSpiTb.sv */
`default_nettype none

module framSpiTb
   import spiCmdPkg::*;
   import memMapPkg::*;
();

   localparam int CLK_PERIOD  = 10;
   localparam int HALF_CYCLES = SCK_MIN_DIV / 2;

   // bytes on the wire per behavior: 2, 6, 51, 179, 10, 7
   localparam int SCRIPT_BYTES    = 255;
   localparam int WATCHDOG_CYCLES = SCRIPT_BYTES * 8 * SCK_MIN_DIV * 2;

   logic CSB;
   logic reset;
   logic chipSelectN;
   logic sck;
   logic sdi;
   logic sdo;

   logic [31:0] lcgState = 32'h4f55;
   spiByteT     refMem [MEM_DEPTH];
   bpT          refBp;
   logic        refWel;
   addrT        regionBase [3];

   framSpiTop UUT
   (
      .CSB         (CSB),
      .reset       (reset),
      .chipSelectN (chipSelectN),
      .sck         (sck),
      .sdi         (sdi),
      .sdo         (sdo)
   );

   // -------------------------------------------------------------------
   // clock and watchdog
   // -------------------------------------------------------------------

   initial
   begin
      CSB = 1'b0;
      forever
         #(CLK_PERIOD / 2) CSB = ~CSB;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

   // -------------------------------------------------------------------
   // reference model
   // -------------------------------------------------------------------

   function automatic logic [31:0] lcgNext();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // status byte seen by the host, busy and upper bits stay zero
   function automatic spiByteT statusByte(input bpT bp, input logic wel);
      return {4'b0000, bp, wel, 1'b0};
   endfunction

   function automatic logic isProtected(input bpT bp, input addrT a);
      logic hit;
      case (bp)
         2'b01:
            hit = (a >= QUARTER_BASE);
         2'b10:
            hit = (a >= HALF_BASE);
         2'b11:
            hit = 1'b1;
         default:
            hit = 1'b0;
      endcase
      return hit;
   endfunction

   function automatic addrT nextAddr(input addrT a);
      return (a == addrT'(MEM_DEPTH - 1)) ? addrT'(0) : addrT'(a + 1);
   endfunction

   task automatic reportMismatch(input string msg);
      $display("MISMATCH at time %0t: %s", $time, msg);
      $display("Simulation FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic expectByte(input spiByteT got, input spiByteT exp, input string what);
      assert (got === exp)
      else
         reportMismatch($sformatf("%s returned %02h, expected %02h", what, got, exp));
   endtask

   // -------------------------------------------------------------------
   // SPI host, mode 0
   // -------------------------------------------------------------------

   task automatic beginSelect();
      @(posedge CSB);
      chipSelectN <= 1'b0;
   endtask

   task automatic endSelect();
      @(posedge CSB);
      sck <= 1'b0;
      repeat (HALF_CYCLES) @(posedge CSB);
      chipSelectN <= 1'b1;
      repeat (HALF_CYCLES) @(posedge CSB);
   endtask

   // data out on the falling edge, sdo captured just before the rise
   task automatic shiftByte(input spiByteT txVal, output spiByteT rxVal);
      for (int i = 7; i >= 0; i--)
      begin
         @(posedge CSB);
         sck <= 1'b0;
         sdi <= txVal[i];
         repeat (HALF_CYCLES - 1) @(posedge CSB);
         @(negedge CSB);
         rxVal[i] = sdo;
         @(posedge CSB);
         sck <= 1'b1;
         repeat (HALF_CYCLES - 1) @(posedge CSB);
      end
   endtask

   task automatic sendOpcode(input opcodeT op);
      spiByteT rx;
      beginSelect();
      shiftByte(op, rx);
      endSelect();
      if (op == opWren)
         refWel = 1'b1;
      else if (op == opWrdi)
         refWel = 1'b0;
   endtask

   task automatic checkStatus();
      spiByteT rx;
      beginSelect();
      shiftByte(opRdsr, rx);
      shiftByte(8'h00, rx);
      endSelect();
      expectByte(rx, statusByte(refBp, refWel), "RDSR");
   endtask

   task automatic sendHeader(input opcodeT op, input addrT a);
      spiByteT rx;
      shiftByte(op, rx);
      shiftByte(spiByteT'(a >> 8), rx);
      shiftByte(a[7:0], rx);
   endtask

   task automatic writeBurst(input addrT start, input int len);
      spiByteT rx;
      spiByteT data;
      addrT    a;
      a = start;
      beginSelect();
      sendHeader(opWrite, start);
      for (int i = 0; i < len; i++)
      begin
         data = spiByteT'(lcgNext() >> 16);
         shiftByte(data, rx);
         if (refWel && !isProtected(refBp, a))
            refMem[a] = data;
         a = nextAddr(a);
      end
      endSelect();
      // latch drops when the write command is deselected
      refWel = 1'b0;
   endtask

   task automatic readBurst(input addrT start, input int len);
      spiByteT rx;
      addrT    a;
      a = start;
      beginSelect();
      sendHeader(opRead, start);
      for (int i = 0; i < len; i++)
      begin
         shiftByte(8'h00, rx);
         expectByte(rx, refMem[a], $sformatf("READ at %04h", a));
         a = nextAddr(a);
      end
      endSelect();
   endtask

   task automatic setProtection(input bpT bp);
      spiByteT rx;
      sendOpcode(opWren);
      beginSelect();
      shiftByte(opWrsr, rx);
      shiftByte({4'b0000, bp, 2'b00}, rx);
      endSelect();
      if (refWel)
         refBp = bp;
      refWel = 1'b0;
      checkStatus();
   endtask

   task automatic protectRound(input bpT bp);
      setProtection(bp);
      for (int r = 0; r < 3; r++)
      begin
         sendOpcode(opWren);
         writeBurst(regionBase[r], 4);
      end
      for (int r = 0; r < 3; r++)
         readBurst(regionBase[r], 4);
   endtask

   task automatic readDeviceId();
      spiByteT rx;
      spiByteT expQ[$];
      for (int i = 0; i < ID_CONT_BYTES; i++)
         expQ.push_back(8'h7F);
      expQ.push_back(ID_CODE[23:16]);
      expQ.push_back(ID_CODE[15:8]);
      expQ.push_back(ID_CODE[7:0]);
      beginSelect();
      shiftByte(opRdid, rx);
      foreach (expQ[i])
      begin
         shiftByte(8'h00, rx);
         expectByte(rx, expQ[i], $sformatf("RDID byte %0d", i));
      end
      endSelect();
   endtask

   // unknown opcode keeps sdo at zero until deselect
   task automatic sendUnknownOpcode();
      spiByteT rx;
      beginSelect();
      shiftByte(8'hA5, rx);
      for (int i = 0; i < 3; i++)
      begin
         shiftByte(spiByteT'(lcgNext() >> 16), rx);
         expectByte(rx, 8'h00, "byte after unknown opcode");
      end
      endSelect();
   endtask

   // -------------------------------------------------------------------
   // test sequence
   // -------------------------------------------------------------------

   initial
   begin
      addrT scratch;
      reset       <= 1'b1;
      chipSelectN <= 1'b1;
      sck         <= 1'b0;
      sdi         <= 1'b0;
      refBp  = '0;
      refWel = 1'b0;
      repeat (3) @(posedge CSB);
      reset <= 1'b0;
      @(negedge CSB);
      assert (sdo === 1'b0)
      else
         reportMismatch("sdo not low after reset");
      checkStatus();

      // write-enable latch set and cleared
      sendOpcode(opWren);
      checkStatus();
      sendOpcode(opWrdi);
      checkStatus();

      // write without WREN must not land
      scratch = addrT'(lcgNext() >> 8);
      sendOpcode(opWren);
      writeBurst(scratch, 4);
      writeBurst(scratch, 4);
      readBurst(scratch, 4);

      // burst across the top address
      scratch = addrT'(MEM_DEPTH - 2 - ((lcgNext() >> 16) % 8));
      sendOpcode(opWren);
      writeBurst(scratch, 10);
      checkStatus();
      readBurst(scratch, 10);

      // regions straddle the protection boundaries
      regionBase[0] = addrT'((lcgNext() >> 8) % (HALF_BASE - 4));
      regionBase[1] = HALF_BASE - addrT'(2);
      regionBase[2] = QUARTER_BASE - addrT'(2);
      for (int r = 0; r < 3; r++)
      begin
         sendOpcode(opWren);
         writeBurst(regionBase[r], 4);
      end
      protectRound(2'b10);
      protectRound(2'b11);
      protectRound(2'b01);
      setProtection(2'b00);

      readDeviceId();
      sendUnknownOpcode();
      // status must show the latch set, which an all-zero sdo cannot fake
      sendOpcode(opWren);
      checkStatus();

      $display("Simulation PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* framSpi.f */
rtl/spiCmdPkg.sv
rtl/memMapPkg.sv
rtl/spiFrontEnd.sv
rtl/cmdSequencer.sv
rtl/framArray.sv
rtl/framSpiTop.sv
bench/framSpiTb.sv

/* Bender.yml */
package:
  name: framSpi

sources:
  # packages first, then the blocks, then the top level
  - rtl/spiCmdPkg.sv
  - rtl/memMapPkg.sv
  - rtl/spiFrontEnd.sv
  - rtl/cmdSequencer.sv
  - rtl/framArray.sv
  - rtl/framSpiTop.sv

  - target: test
    files:
      - bench/framSpiTb.sv
